//--- include/vcr_stim_table.svh
// packet stimulus entry type and table of packets with expected output ports
`ifndef vcr_stim_table_svh
`define vcr_stim_table_svh

// one packet to send through the router at address (1,1)
typedef struct packed {
   logic         sync;
   logic         hold;
   port_idx_t    in_port;
   vc_idx_t      vc;
   router_addr_t dest;
   logic [4:0]   len;
   port_idx_t    exp_port;
} stim_t;

localparam int num_stim = 19;

// columns: sync, hold, input port, vc, dest (x,y), length, expected output port
// sync waits for all earlier traffic to drain, hold withholds sink credits on that output vc
localparam stim_t stim_table [num_stim] = '{
   // every output port, each output vc used by one input only
   '{1'b1, 1'b0, port_local,  1'b0, '{2'd2, 2'd1}, 5'd3,  port_xplus},
   '{1'b0, 1'b0, port_local,  1'b1, '{2'd0, 2'd1}, 5'd2,  port_xminus},
   '{1'b0, 1'b0, port_xminus, 1'b0, '{2'd1, 2'd0}, 5'd4,  port_yminus},
   '{1'b0, 1'b0, port_xplus,  1'b1, '{2'd1, 2'd3}, 5'd1,  port_yplus},
   '{1'b0, 1'b0, port_yminus, 1'b0, '{2'd1, 2'd1}, 5'd3,  port_local},
   '{1'b0, 1'b0, port_yplus,  1'b1, '{2'd3, 2'd0}, 5'd2,  port_xplus},
   '{1'b0, 1'b0, port_yminus, 1'b0, '{2'd0, 2'd2}, 5'd2,  port_xminus},
   '{1'b0, 1'b0, port_xminus, 1'b1, '{2'd1, 2'd1}, 5'd2,  port_local},
   '{1'b0, 1'b0, port_xplus,  1'b0, '{2'd1, 2'd2}, 5'd1,  port_yplus},
   '{1'b0, 1'b0, port_yplus,  1'b1, '{2'd1, 2'd0}, 5'd3,  port_yminus},
   // two inputs on one output vc, the first head wins the vc
   '{1'b1, 1'b0, port_xminus, 1'b0, '{2'd1, 2'd3}, 5'd5,  port_yplus},
   '{1'b0, 1'b0, port_yminus, 1'b0, '{2'd1, 2'd3}, 5'd4,  port_yplus},
   '{1'b0, 1'b0, port_xplus,  1'b1, '{2'd1, 2'd2}, 5'd3,  port_yplus},
   // long packet into an output vc whose credits are withheld
   '{1'b1, 1'b1, port_local,  1'b1, '{2'd2, 2'd1}, 5'd10, port_xplus},
   // mixed load after the release
   '{1'b1, 1'b0, port_xminus, 1'b1, '{2'd3, 2'd3}, 5'd6,  port_xplus},
   '{1'b0, 1'b0, port_xplus,  1'b0, '{2'd0, 2'd0}, 5'd6,  port_xminus},
   '{1'b0, 1'b0, port_yminus, 1'b1, '{2'd1, 2'd1}, 5'd4,  port_local},
   '{1'b0, 1'b0, port_yplus,  1'b0, '{2'd2, 2'd0}, 5'd5,  port_xplus},
   '{1'b0, 1'b0, port_local,  1'b0, '{2'd1, 2'd0}, 5'd3,  port_yminus}
};

`endif

//--- bench/vcr_tb.sv
// router testbench with clock, reset, source and sink models, scoreboard and table loop
`timescale 1ns/1ns

module vcr_tb
   import vcr_pkg::*;
();

   localparam int buffer_depth   = 4;
   localparam int timeout_cycles = 2000;

`include "vcr_stim_table.svh"

   // pending credit return of a sink
   typedef struct {
      int due;
      int vc;
   } ret_t;

   logic          clk;
   logic          rst_n;
   router_addr_t  router_address;
   flit_channel_t channel_in  [num_ports];
   credit_t       credit_out  [num_ports];
   flit_channel_t channel_out [num_ports];
   credit_t       credit_in   [num_ports];
   logic          error;

   flit_channel_t src_q       [num_ports][$];
   int            src_credits [num_ports][num_vcs];
   flit_channel_t exp_q       [num_ports][num_vcs][$];
   int            rcv_cnt     [num_ports][num_vcs];
   ret_t          ret_q       [num_ports][$];
   logic          hold_on;
   int            hold_port;
   int            hold_vc;
   int            hold_base;
   logic          inject_req;
   int            inject_port;
   flit_channel_t inject_flit;
   int            seed;
   int            errors;
   int            timeouts;
   int            cycle;

   vcr_top #(
      .buffer_depth(buffer_depth)
   ) vcr_top_i (
      .clk(clk),
      .rst_n(rst_n),
      .router_address(router_address),
      .channel_in(channel_in),
      .credit_out(credit_out),
      .channel_out(channel_out),
      .credit_in(credit_in),
      .error(error)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   // ----------------------------------------------------------
   // reporting helpers
   // ----------------------------------------------------------
   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
      errors++;
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, want);
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("%0t %s", $time, msg);
   endtask

   task automatic report_timeout(input string msg);
      timeouts++;
      $display("%0t timeout, %s", $time, msg);
   endtask

   function automatic logic withheld(input int p, input int v);
      return hold_on && (hold_port == p) && (hold_vc == v);
   endfunction

   function automatic logic traffic_left();
      logic busy;
      busy = 1'b0;
      for (int p = 0; p < num_ports; p++)
      begin
         busy |= (src_q[p].size() != 0) || (ret_q[p].size() != 0);
         for (int v = 0; v < num_vcs; v++)
            busy |= (exp_q[p][v].size() != 0);
      end
      return busy;
   endfunction

   // ----------------------------------------------------------
   // upstream sources send one flit per port and cycle while credits last
   // ----------------------------------------------------------
   always @(negedge clk)
   begin
      for (int p = 0; p < num_ports; p++)
      begin
         channel_in[p] = '0;
         if (!rst_n)
         begin
            for (int v = 0; v < num_vcs; v++)
               src_credits[p][v] = buffer_depth;
         end
         else
         begin
            if (credit_out[p].valid)
            begin
               src_credits[p][credit_out[p].vc]++;
               assert (src_credits[p][credit_out[p].vc] <= buffer_depth)
               else
                  report_failure($sformatf("input %0d returned a credit for no flit", p));
            end
            // protocol violation from the error test goes out without a credit
            if (inject_req && (inject_port == p))
               channel_in[p] = inject_flit;
            else if ((src_q[p].size() != 0) && (src_credits[p][src_q[p][0].vc] > 0))
            begin
               channel_in[p] = src_q[p].pop_front();
               src_credits[p][channel_in[p].vc]--;
            end
         end
      end
      inject_req = 1'b0;
   end

   // ----------------------------------------------------------
   // downstream sinks and scoreboard
   // ----------------------------------------------------------
   task automatic score_flit(input int p, input flit_channel_t got);
      flit_channel_t want;
      ret_t          r;
      rcv_cnt[p][got.vc]++;
      // credit goes back after a random delay of 1 to 4 cycles
      r.due = cycle + 1 + int'($unsigned($random(seed)) % 4);
      r.vc  = int'(got.vc);
      ret_q[p].push_back(r);
      assert (exp_q[p][got.vc].size() != 0)
      else
         report_failure($sformatf("unexpected flit on output %0d vc %0d", p, got.vc));
      if (exp_q[p][got.vc].size() != 0)
      begin
         want = exp_q[p][got.vc].pop_front();
         assert (got === want)
         else
            report_mismatch($sformatf("channel_out[%0d]", p), got, want);
      end
      if (withheld(p, int'(got.vc)))
         assert (rcv_cnt[p][got.vc] - hold_base <= buffer_depth)
         else
            report_failure($sformatf("output %0d sent a flit with no credit left", p));
   endtask

   always @(negedge clk)
   begin
      int k;
      cycle++;
      for (int p = 0; p < num_ports; p++)
      begin
         credit_in[p] = '0;
         if (!rst_n)
            ret_q[p].delete();
         else
         begin
            if (channel_out[p].valid)
               score_flit(p, channel_out[p]);
            // pick the oldest due return that is not withheld
            k = -1;
            for (int i = ret_q[p].size() - 1; i >= 0; i--)
               if ((ret_q[p][i].due <= cycle) && !withheld(p, ret_q[p][i].vc))
                  k = i;
            if (k >= 0)
            begin
               credit_in[p].valid = 1'b1;
               credit_in[p].vc    = vc_idx_t'(ret_q[p][k].vc);
               ret_q[p].delete(k);
            end
         end
      end
   end

   // ----------------------------------------------------------
   // sequencing
   // ----------------------------------------------------------
   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic check_reset_state();
      for (int p = 0; p < num_ports; p++)
      begin
         assert (channel_out[p].valid === 1'b0)
         else
            report_mismatch($sformatf("channel_out[%0d].valid", p), channel_out[p].valid, 0);
         assert (credit_out[p].valid === 1'b0)
         else
            report_mismatch($sformatf("credit_out[%0d].valid", p), credit_out[p].valid, 0);
      end
      assert (error === 1'b0)
      else
         report_mismatch("error", error, 0);
   endtask

   task automatic wait_idle();
      int t;
      t = 0;
      while (traffic_left() && (t < timeout_cycles))
      begin
         @(posedge clk);
         t++;
      end
      assert (!traffic_left())
      else
         report_timeout("traffic did not drain");
      // idle inputs have returned every credit
      for (int p = 0; p < num_ports; p++)
         for (int v = 0; v < num_vcs; v++)
            assert (src_credits[p][v] == buffer_depth)
            else
               report_mismatch($sformatf("credit_out[%0d] vc %0d count", p, v),
                               src_credits[p][v], buffer_depth);
   endtask

   task automatic run_entry(input stim_t s, input int idx);
      flit_channel_t f;
      int            t;
      if (s.sync)
         wait_idle();
      @(posedge clk);
      if (s.hold)
      begin
         hold_port = int'(s.exp_port);
         hold_vc   = int'(s.vc);
         hold_base = rcv_cnt[s.exp_port][s.vc];
         hold_on   = 1'b1;
      end
      for (int n = 0; n < s.len; n++)
      begin
         f       = '0;
         f.valid = 1'b1;
         f.head  = (n == 0);
         f.tail  = (n == s.len - 1);
         f.vc    = s.vc;
         if (n == 0)
         begin
            f.payload.header.dest = s.dest;
            f.payload.header.tag  = 28'(idx);
         end
         else
            f.payload.data = $random(seed);
         src_q[s.in_port].push_back(f);
         // scoreboard entry on the output the table predicts
         exp_q[s.exp_port][s.vc].push_back(f);
      end
      if (s.hold)
      begin
         t = 0;
         while ((rcv_cnt[s.exp_port][s.vc] - hold_base < buffer_depth) && (t < timeout_cycles))
         begin
            @(posedge clk);
            t++;
         end
         assert (rcv_cnt[s.exp_port][s.vc] - hold_base >= buffer_depth)
         else
            report_timeout("held output vc never used its credits");
         // extra flits during this window are caught by the sink
         repeat (10) @(posedge clk);
         assert (src_credits[s.in_port][s.vc] == 0)
         else
            report_mismatch("upstream credit count", src_credits[s.in_port][s.vc], 0);
         hold_on = 1'b0;
      end
   endtask

   task automatic check_sticky_error();
      int t;
      @(negedge clk);
      assert (error === 1'b0)
      else
         report_mismatch("error", error, 0);
      // body flit on the idle vc 1 of the x-plus input
      @(posedge clk);
      inject_flit              = '0;
      inject_flit.valid        = 1'b1;
      inject_flit.vc           = 1'b1;
      inject_flit.payload.data = 32'h0bad_f117;
      inject_port              = int'(port_xplus);
      inject_req               = 1'b1;
      t = 0;
      while ((error !== 1'b1) && (t < timeout_cycles))
      begin
         @(negedge clk);
         t++;
      end
      assert (error === 1'b1)
      else
         report_timeout("error did not rise after a body flit on an idle vc");
      repeat (8) @(negedge clk);
      assert (error === 1'b1)
      else
         report_mismatch("error", error, 1);
      apply_reset();
      assert (error === 1'b0)
      else
         report_mismatch("error", error, 0);
   endtask

   initial
   begin
      seed           = 40;
      errors         = 0;
      timeouts       = 0;
      cycle          = 0;
      hold_on        = 1'b0;
      hold_port      = 0;
      hold_vc        = 0;
      hold_base      = 0;
      inject_req     = 1'b0;
      inject_port    = 0;
      inject_flit    = '0;
      rst_n          = 1'b0;
      router_address = '{x: 2'd1, y: 2'd1};
      for (int p = 0; p < num_ports; p++)
      begin
         channel_in[p] = '0;
         credit_in[p]  = '0;
         for (int v = 0; v < num_vcs; v++)
         begin
            src_credits[p][v] = buffer_depth;
            rcv_cnt[p][v]     = 0;
         end
      end
      apply_reset();
      check_reset_state();
      for (int i = 0; i < num_stim; i++)
         run_entry(stim_table[i], i);
      wait_idle();
      check_sticky_error();
      $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+include
rtl/vcr_pkg.sv
rtl/vcr_input_port.sv
rtl/vcr_alloc.sv
rtl/vcr_output_port.sv
rtl/vcr_top.sv
bench/vcr_tb.sv

//--- rtl/vcr_alloc.sv
// VC allocator and separable input-first switch allocator with round-robin pointers
`timescale 1ns/1ns

module vcr_alloc
   import vcr_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  port_idx_t            route        [num_ports][num_vcs],
   input  logic [num_vcs-1:0]   head_pending [num_ports],
   input  logic [num_vcs-1:0]   flit_ready   [num_ports],
   input  logic [num_vcs-1:0]   ovc_free     [num_ports],
   input  logic [num_vcs-1:0]   credit_avail [num_ports],
   output logic [num_vcs-1:0]   vc_gnt       [num_ports],
   output logic [num_ports-1:0] sw_gnt,
   output vc_idx_t              sw_gnt_vc    [num_ports],
   output logic [num_vcs-1:0]   vc_claim     [num_ports],
   output logic [num_ports-1:0] sw_sel       [num_ports],
   output logic [num_ports-1:0] sw_valid
);

   localparam int pw = $bits(port_idx_t);

   // first requester at or after the pointer
   function automatic logic [pw-1:0] rr_pick(input logic [num_ports-1:0] req,
                                             input logic [pw-1:0] ptr);
      logic [pw-1:0] win;
      int            k;
      win = ptr;
      // walk backwards so the nearest requester is written last
      for (int i = num_ports - 1; i >= 0; i--)
      begin
         k = (int'(ptr) + i) % num_ports;
         if (req[k])
            win = pw'(k);
      end
      return win;
   endfunction

   // pointer moves just past the winner
   function automatic logic [pw-1:0] rr_next(input logic [pw-1:0] win, input int n);
      return (int'(win) == n - 1) ? '0 : win + 1'b1;
   endfunction

   logic [pw-1:0]       vc_ptr [num_ports][num_vcs];
   logic [pw-1:0]       vc_win [num_ports][num_vcs];
   vc_idx_t             in_ptr [num_ports];
   vc_idx_t             in_pick [num_ports];
   logic [num_ports-1:0] in_any;
   logic [pw-1:0]       out_ptr [num_ports];
   logic [pw-1:0]       out_win [num_ports];

   // ----------------------------------------------------------
   // VC allocation, a packet keeps its VC index
   // ----------------------------------------------------------
   always_comb
   begin
      logic [num_ports-1:0] req;
      for (int ip = 0; ip < num_ports; ip++)
         vc_gnt[ip] = '0;
      for (int op = 0; op < num_ports; op++)
      begin
         for (int v = 0; v < num_vcs; v++)
         begin
            // only waiting heads bound for this free output VC
            for (int ip = 0; ip < num_ports; ip++)
               req[ip] = head_pending[ip][v] && (route[ip][v] == port_idx_t'(op))
                         && ovc_free[op][v];
            vc_win[op][v]   = rr_pick(req, vc_ptr[op][v]);
            vc_claim[op][v] = |req;
            if (|req)
               vc_gnt[vc_win[op][v]][v] = 1'b1;
         end
      end
   end

   // ----------------------------------------------------------
   // switch allocation, input stage then output stage
   // ----------------------------------------------------------
   always_comb
   begin
      logic [num_ports-1:0] vreq;
      logic [num_ports-1:0] oreq;
      // each input offers one ready VC that has a downstream credit
      for (int ip = 0; ip < num_ports; ip++)
      begin
         vreq = '0;
         for (int v = 0; v < num_vcs; v++)
            vreq[v] = flit_ready[ip][v] && credit_avail[route[ip][v]][v];
         in_any[ip]    = |vreq;
         in_pick[ip]   = vc_idx_t'(rr_pick(vreq, pw'(in_ptr[ip])));
         sw_gnt_vc[ip] = in_pick[ip];
      end
      sw_gnt = '0;
      // each output takes one of the inputs offering to it
      for (int op = 0; op < num_ports; op++)
      begin
         for (int ip = 0; ip < num_ports; ip++)
            oreq[ip] = in_any[ip] && (route[ip][in_pick[ip]] == port_idx_t'(op));
         out_win[op]  = rr_pick(oreq, out_ptr[op]);
         sw_valid[op] = |oreq;
         sw_sel[op]   = (|oreq) ? (num_ports'(1) << out_win[op]) : '0;
         sw_gnt       = sw_gnt | sw_sel[op];
      end
   end

   // pointers only advance on a grant
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int p = 0; p < num_ports; p++)
         begin
            for (int v = 0; v < num_vcs; v++)
               vc_ptr[p][v] <= '0;
            in_ptr[p]  <= '0;
            out_ptr[p] <= '0;
         end
      end
      else
      begin
         for (int p = 0; p < num_ports; p++)
         begin
            for (int v = 0; v < num_vcs; v++)
               if (vc_claim[p][v])
                  vc_ptr[p][v] <= rr_next(vc_win[p][v], num_ports);
            if (sw_gnt[p])
               in_ptr[p] <= vc_idx_t'(rr_next(pw'(in_pick[p]), num_vcs));
            if (sw_valid[p])
               out_ptr[p] <= rr_next(out_win[p], num_ports);
         end
      end
   end

endmodule

//--- rtl/vcr_input_port.sv
// input port with per-VC flit FIFOs, dimension-order routing, packet state, credit return, errors
`timescale 1ns/1ns

module vcr_input_port
   import vcr_pkg::*;
#(
   parameter int buffer_depth = 4
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  router_addr_t       router_address,
   input  flit_channel_t      channel_in,
   input  logic [num_vcs-1:0] vc_gnt,
   input  logic               sw_gnt,
   input  vc_idx_t            sw_gnt_vc,
   output port_idx_t          route [num_vcs],
   output logic [num_vcs-1:0] head_pending,
   output logic [num_vcs-1:0] flit_ready,
   output flit_channel_t      flit_out,
   output credit_t            credit_out,
   output logic               error_flag
);

   localparam int ptr_w = $clog2(buffer_depth);
   localparam int cnt_w = $clog2(buffer_depth + 1);

   // idle: no packet at the buffer head
   // waiting: head flit asked for its output VC and lost
   // active: output VC held until the tail leaves
   typedef enum logic [1:0] {
      vc_idle,
      vc_waiting,
      vc_active
   } vc_state_t;

   flit_channel_t      front [num_vcs];
   logic [num_vcs-1:0] err_full;
   logic [num_vcs-1:0] err_orphan;

   for (genvar v = 0; v < num_vcs; v++)
   begin : vcs
      flit_channel_t    mem [buffer_depth];
      logic [ptr_w-1:0] rd_ptr;
      logic [ptr_w-1:0] wr_ptr;
      logic [cnt_w-1:0] count;
      logic             arrive;
      logic             full;
      logic             push;
      logic             pop;
      logic             in_pkt;
      vc_state_t        state;
      port_idx_t        route_c;
      port_idx_t        route_q;
      router_addr_t     dest;

      // ----------------------------------------------------------
      // arrival side
      // ----------------------------------------------------------
      assign arrive = channel_in.valid && (channel_in.vc == vc_idx_t'(v));
      assign full   = (count == cnt_w'(buffer_depth));

      // upstream overran its credits
      assign err_full[v] = arrive && full;
      // body or tail with no open packet on this VC
      assign err_orphan[v] = arrive && !channel_in.head && !in_pkt;

      // offending flits are dropped so the buffer stays well formed
      assign push = arrive && !full && (channel_in.head || in_pkt);
      assign pop  = sw_gnt && (sw_gnt_vc == vc_idx_t'(v));

      always_ff @(posedge clk)
      begin
         if (push)
         begin
            mem[wr_ptr] <= channel_in;
         end
      end

      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
         begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            in_pkt <= 1'b0;
         end
         else
         begin
            if (push)
            begin
               wr_ptr <= (wr_ptr == ptr_w'(buffer_depth - 1)) ? '0 : wr_ptr + 1'b1;
               // packet stays open from head to tail
               in_pkt <= !channel_in.tail;
            end
            if (pop)
            begin
               rd_ptr <= (rd_ptr == ptr_w'(buffer_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
               2'b10:   count <= count + 1'b1;
               2'b01:   count <= count - 1'b1;
               default: count <= count;
            endcase
         end
      end

      // ----------------------------------------------------------
      // routing and packet state
      // ----------------------------------------------------------
      assign front[v] = mem[rd_ptr];
      assign dest     = front[v].payload.header.dest;

      // x first, then y, equal address goes to the local port
      always_comb
      begin
         if (dest.x > router_address.x)
            route_c = port_xplus;
         else if (dest.x < router_address.x)
            route_c = port_xminus;
         else if (dest.y > router_address.y)
            route_c = port_yplus;
         else if (dest.y < router_address.y)
            route_c = port_yminus;
         else
            route_c = port_local;
      end

      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
         begin
            state   <= vc_idle;
            route_q <= port_local;
         end
         else
         begin
            if (vc_gnt[v])
            begin
               route_q <= route_c;
            end
            case (state)
               vc_idle:
                  if (head_pending[v])
                     state <= vc_gnt[v] ? vc_active : vc_waiting;
               vc_waiting:
                  if (vc_gnt[v])
                     state <= vc_active;
               default:
                  if (pop && front[v].tail)
                     state <= vc_idle;
            endcase
         end
      end

      // body flits follow the route latched from their head
      assign route[v]        = (state == vc_active) ? route_q : route_c;
      assign head_pending[v] = (state != vc_active) && (count != '0) && front[v].head;
      assign flit_ready[v]   = (state == vc_active) && (count != '0);
   end

   // ----------------------------------------------------------
   // crossbar feed and credit return
   // ----------------------------------------------------------
   always_comb
   begin
      flit_out       = front[sw_gnt_vc];
      flit_out.valid = sw_gnt;
      flit_out.vc    = sw_gnt_vc;
   end

   // one credit per drained flit, a cycle after it leaves
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         credit_out <= '0;
      end
      else
      begin
         credit_out.valid <= sw_gnt;
         credit_out.vc    <= sw_gnt_vc;
      end
   end

   assign error_flag = |{err_full, err_orphan};

endmodule

//--- rtl/vcr_output_port.sv
// output port with crossbar column, output-VC ownership, credit counters and channel register
`timescale 1ns/1ns

module vcr_output_port
   import vcr_pkg::*;
#(
   parameter int buffer_depth = 4
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  flit_channel_t        flit_in [num_ports],
   input  logic [num_ports-1:0] sw_sel,
   input  logic                 sw_valid,
   input  logic [num_vcs-1:0]   vc_claim,
   input  credit_t              credit_in,
   output flit_channel_t        channel_out,
   output logic [num_vcs-1:0]   ovc_free,
   output logic [num_vcs-1:0]   credit_avail
);

   localparam int cnt_w = $clog2(buffer_depth + 1);

   flit_channel_t      xbar_flit;
   logic [cnt_w-1:0]   credits [num_vcs];
   logic [num_vcs-1:0] owned;

   // ----------------------------------------------------------
   // crossbar column, AND-OR mux on the one-hot select
   // ----------------------------------------------------------
   always_comb
   begin
      xbar_flit = '0;
      for (int ip = 0; ip < num_ports; ip++)
      begin
         if (sw_sel[ip])
            xbar_flit = xbar_flit | flit_in[ip];
      end
      xbar_flit.valid = sw_valid;
   end

   // registered link toward the downstream router
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         channel_out <= '0;
      else
         channel_out <= xbar_flit;
   end

   // ----------------------------------------------------------
   // per-VC credits and ownership
   // ----------------------------------------------------------
   for (genvar v = 0; v < num_vcs; v++)
   begin : ovcs
      logic sent;
      logic returned;

      assign sent     = xbar_flit.valid && (xbar_flit.vc == vc_idx_t'(v));
      assign returned = credit_in.valid && (credit_in.vc == vc_idx_t'(v));

      // counter starts at the downstream buffer depth
      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
            credits[v] <= cnt_w'(buffer_depth);
         else if (sent && !returned)
            credits[v] <= credits[v] - 1'b1;
         else if (returned && !sent)
            credits[v] <= credits[v] + 1'b1;
      end

      // claimed by a head grant, released as the tail goes out
      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
            owned[v] <= 1'b0;
         else if (vc_claim[v])
            owned[v] <= 1'b1;
         else if (sent && xbar_flit.tail)
            owned[v] <= 1'b0;
      end

      assign credit_avail[v] = (credits[v] != '0);
   end

   assign ovc_free = ~owned;

endmodule

//--- rtl/vcr_pkg.sv
// router sizes, port enumeration, address and header structs, payload union, flit channel, credit
package vcr_pkg;

   // ----------------------------------------------------------
   // sizes
   // ----------------------------------------------------------

   // x-minus, x-plus, y-minus, y-plus and local
   localparam int num_ports = 5;

   // two VCs on every port
   localparam int num_vcs = 2;

   // 4x4 mesh, so two address bits per dimension
   localparam int dim_addr_width = 2;

   // flit payload width
   localparam int flit_data_width = 32;

   // ----------------------------------------------------------
   // indices
   // ----------------------------------------------------------

   // port numbering used by route and crossbar select
   typedef enum logic [2:0] {
      port_xminus = 3'd0,
      port_xplus  = 3'd1,
      port_yminus = 3'd2,
      port_yplus  = 3'd3,
      port_local  = 3'd4
   } port_idx_t;

   typedef logic [0:0] vc_idx_t;

   // ----------------------------------------------------------
   // flit format
   // ----------------------------------------------------------

   // router coordinates in the mesh
   typedef struct packed {
      logic [dim_addr_width-1:0] x;
      logic [dim_addr_width-1:0] y;
   } router_addr_t;

   // head flit payload, destination in the upper bits
   typedef struct packed {
      router_addr_t                                dest;
      logic [flit_data_width-2*dim_addr_width-1:0] tag;
   } route_header_t;

   // read as header when the flit has head set, as raw data otherwise
   typedef union packed {
      route_header_t              header;
      logic [flit_data_width-1:0] data;
   } flit_payload_u;

   // one link cycle, 36 bits
   typedef struct packed {
      logic          valid;
      logic          head;
      logic          tail;
      vc_idx_t       vc;
      flit_payload_u payload;
   } flit_channel_t;

   // credit return, one per flit drained from a buffer
   typedef struct packed {
      logic    valid;
      vc_idx_t vc;
   } credit_t;

endpackage

//--- rtl/vcr_top.sv
// router top with input and output port arrays, allocator, crossbar wiring and sticky error
`timescale 1ns/1ns

module vcr_top
   import vcr_pkg::*;
#(
   parameter int buffer_depth = 4
)
(
   input  logic          clk,
   input  logic          rst_n,
   input  router_addr_t  router_address,
   input  flit_channel_t channel_in  [num_ports],
   output credit_t       credit_out  [num_ports],
   output flit_channel_t channel_out [num_ports],
   input  credit_t       credit_in   [num_ports],
   output logic          error
);

   port_idx_t            route        [num_ports][num_vcs];
   logic [num_vcs-1:0]   head_pending [num_ports];
   logic [num_vcs-1:0]   flit_ready   [num_ports];
   logic [num_vcs-1:0]   vc_gnt       [num_ports];
   logic [num_vcs-1:0]   ovc_free     [num_ports];
   logic [num_vcs-1:0]   credit_avail [num_ports];
   logic [num_vcs-1:0]   vc_claim     [num_ports];
   logic [num_ports-1:0] sw_sel       [num_ports];
   logic [num_ports-1:0] sw_gnt;
   logic [num_ports-1:0] sw_valid;
   vc_idx_t              sw_gnt_vc    [num_ports];
   // head flit of every input, fanned into each output column
   flit_channel_t        xbar_in      [num_ports];
   logic [num_ports-1:0] ip_error;

   // ----------------------------------------------------------
   // input ports
   // ----------------------------------------------------------
   for (genvar ip = 0; ip < num_ports; ip++)
   begin : ips
      vcr_input_port #(
         .buffer_depth(buffer_depth)
      ) ipc (
         .clk(clk),
         .rst_n(rst_n),
         .router_address(router_address),
         .channel_in(channel_in[ip]),
         .vc_gnt(vc_gnt[ip]),
         .sw_gnt(sw_gnt[ip]),
         .sw_gnt_vc(sw_gnt_vc[ip]),
         .route(route[ip]),
         .head_pending(head_pending[ip]),
         .flit_ready(flit_ready[ip]),
         .flit_out(xbar_in[ip]),
         .credit_out(credit_out[ip]),
         .error_flag(ip_error[ip])
      );
   end

   // ----------------------------------------------------------
   // VC and switch allocation
   // ----------------------------------------------------------
   vcr_alloc alo (
      .clk(clk),
      .rst_n(rst_n),
      .route(route),
      .head_pending(head_pending),
      .flit_ready(flit_ready),
      .ovc_free(ovc_free),
      .credit_avail(credit_avail),
      .vc_gnt(vc_gnt),
      .sw_gnt(sw_gnt),
      .sw_gnt_vc(sw_gnt_vc),
      .vc_claim(vc_claim),
      .sw_sel(sw_sel),
      .sw_valid(sw_valid)
   );

   // ----------------------------------------------------------
   // output ports
   // ----------------------------------------------------------
   for (genvar op = 0; op < num_ports; op++)
   begin : ops
      vcr_output_port #(
         .buffer_depth(buffer_depth)
      ) opc (
         .clk(clk),
         .rst_n(rst_n),
         .flit_in(xbar_in),
         .sw_sel(sw_sel[op]),
         .sw_valid(sw_valid[op]),
         .vc_claim(vc_claim[op]),
         .credit_in(credit_in[op]),
         .channel_out(channel_out[op]),
         .ovc_free(ovc_free[op]),
         .credit_avail(credit_avail[op])
      );
   end

   // any protocol violation latches until reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         error <= 1'b0;
      else if (|ip_error)
         error <= 1'b1;
   end

endmodule
